/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

  // Geometry of the L2 array
  localparam int SET_NUM = 64;
  localparam int WAY_NUM = 4;
  localparam int OFFSET_BITS = 4;

  localparam int SET_BITS = $clog2(SET_NUM);
  localparam int WAY_BITS = $clog2(WAY_NUM);
  // Byte address is 32 bits wide
  localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS;

  typedef logic [SET_BITS-1:0] set_idx_t;
  typedef logic [WAY_BITS-1:0] way_idx_t;
  typedef logic [TAG_BITS-1:0] tag_t;

endpackage

`default_nettype wire

/* bus_pkg.sv */
`default_nettype none

package bus_pkg;

  localparam int BLOCK_BITS = 128;
  localparam int ADDR_BITS = 32;

  typedef logic [BLOCK_BITS-1:0] block_t;
  typedef logic [ADDR_BITS-1:0] addr_t;

  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_cmd_e;

  typedef enum logic [1:0] {
    LOOKUP,
    WRITEBACK,
    ALLOCATE
  } ctrl_state_e;

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ
  } bridge_state_e;

endpackage

`default_nettype wire

/* l1_l2_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface l1_l2_if
  import bus_pkg::*;
();

  // Request fields hold until resp_ready
  logic   req_valid;
  logic   req_wen;
  addr_t  req_addr;
  block_t req_wdata;

  // One-cycle answer from the cache
  logic   resp_ready;
  block_t resp_rdata;

  modport bridge_mp (
    output req_valid,
    output req_wen,
    output req_addr,
    output req_wdata,
    input  resp_ready,
    input  resp_rdata
  );

  modport cache_mp (
    input  req_valid,
    input  req_wen,
    input  req_addr,
    input  req_wdata,
    output resp_ready,
    output resp_rdata
  );

endinterface

`default_nettype wire

/* l1_l2_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module l1_l2_bridge
  import bus_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n,
  input  logic            l1_valid,
  input  logic            l1_wen,
  input  addr_t           l1_addr,
  input  block_t          l1_wdata,
  output logic            l1_ready,
  output block_t          l1_rdata,
  l1_l2_if.bridge_mp      bus
);

  bridge_state_e state_q, state_d;
  addr_t  addr_q;
  block_t wdata_q;

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the request when the decision is taken
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && l1_valid) begin
      addr_q  <= l1_addr;
      wdata_q <= l1_wdata;
    end
  end

  always_comb begin
    state_d        = state_q;
    l1_ready       = 1'b0;
    l1_rdata       = '0;
    bus.req_valid  = 1'b0;
    bus.req_wen    = 1'b0;
    bus.req_addr   = '0;
    bus.req_wdata  = '0;

    case (state_q)
      IDLE: begin
        if (l1_valid) begin
          state_d = l1_wen ? WRITE : READ;
        end
      end
      WRITE: begin
        bus.req_valid = 1'b1;
        bus.req_wen   = 1'b1;
        bus.req_addr  = addr_q;
        bus.req_wdata = wdata_q;
        l1_ready      = bus.resp_ready;
        if (bus.resp_ready) begin
          state_d = IDLE;
        end
      end
      READ: begin
        bus.req_valid = 1'b1;
        bus.req_addr  = addr_q;
        l1_ready      = bus.resp_ready;
        if (bus.resp_ready) begin
          l1_rdata = bus.resp_rdata;
          state_d  = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

endmodule

`default_nettype wire

/* l2_array.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_array
  import cache_pkg::*;
  import bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n,
  input  set_idx_t lookup_set,
  input  tag_t     lookup_tag,
  output logic     hit,
  output way_idx_t hit_way,
  input  way_idx_t rd_way,
  output block_t   rd_data,
  output tag_t     rd_tag,
  output logic     rd_dirty,
  input  logic     wr_en,
  input  way_idx_t wr_way,
  input  block_t   wr_data,
  input  tag_t     wr_tag,
  input  logic     wr_dirty
);

  logic [WAY_NUM-1:0] valid_q [SET_NUM];
  logic [WAY_NUM-1:0] dirty_q [SET_NUM];
  tag_t   tag_q  [SET_NUM][WAY_NUM];
  block_t data_q [SET_NUM][WAY_NUM];

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < SET_NUM; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
    end else if (wr_en) begin
      valid_q[lookup_set][wr_way] <= 1'b1;
      dirty_q[lookup_set][wr_way] <= wr_dirty;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      tag_q[lookup_set][wr_way]  <= wr_tag;
      data_q[lookup_set][wr_way] <= wr_data;
    end
  end

  // All ways of the set compared at once, lowest way wins
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (!hit && valid_q[lookup_set][w] && tag_q[lookup_set][w] == lookup_tag) begin
        hit     = 1'b1;
        hit_way = way_idx_t'(w);
      end
    end
  end

  assign rd_data  = data_q[lookup_set][rd_way];
  assign rd_tag   = tag_q[lookup_set][rd_way];
  assign rd_dirty = valid_q[lookup_set][rd_way] & dirty_q[lookup_set][rd_way];

endmodule

`default_nettype wire

/* l2_lru.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_lru
  import cache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n,
  input  set_idx_t set_idx,
  input  logic     touch,
  input  way_idx_t touch_way,
  output way_idx_t victim_way
);

  // Entry 0 is the most recent way, the last entry the least recent
  way_idx_t order_q [SET_NUM][WAY_NUM];
  way_idx_t next_list [WAY_NUM];
  logic     passed;

  assign victim_way = order_q[set_idx][WAY_NUM-1];

  // Ways in front of the touched one slide back by one place
  always_comb begin
    passed       = 1'b0;
    next_list[0] = touch_way;
    for (int i = 1; i < WAY_NUM; i++) begin
      if (order_q[set_idx][i-1] == touch_way) begin
        passed = 1'b1;
      end
      next_list[i] = passed ? order_q[set_idx][i] : order_q[set_idx][i-1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < SET_NUM; s++) begin
        for (int i = 0; i < WAY_NUM; i++) begin
          order_q[s][i] <= way_idx_t'(i);
        end
      end
    end else if (touch) begin
      for (int i = 0; i < WAY_NUM; i++) begin
        order_q[set_idx][i] <= next_list[i];
      end
    end
  end

endmodule

`default_nettype wire

/* l2_cache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_cache_ctrl
  import cache_pkg::*;
  import bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n,
  l1_l2_if.cache_mp   bus,
  output logic        mem_valid,
  output mem_cmd_e    mem_cmd,
  output addr_t       mem_addr,
  output block_t      mem_wdata,
  input  logic        mem_ready,
  input  block_t      mem_rdata,
  output set_idx_t    lookup_set,
  output tag_t        lookup_tag,
  input  logic        hit,
  input  way_idx_t    hit_way,
  output way_idx_t    rd_way,
  input  block_t      rd_data,
  input  tag_t        rd_tag,
  input  logic        rd_dirty,
  output logic        wr_en,
  output way_idx_t    wr_way,
  output block_t      wr_data,
  output tag_t        wr_tag,
  output logic        wr_dirty,
  output logic        touch,
  output way_idx_t    touch_way,
  input  way_idx_t    victim_way
);

  ctrl_state_e state_q, state_d;

  assign lookup_tag = bus.req_addr[ADDR_BITS-1 -: TAG_BITS];
  assign lookup_set = bus.req_addr[OFFSET_BITS +: SET_BITS];

  // Victim stays put through a miss, no touch happens before the install
  assign rd_way = (state_q == LOOKUP && hit) ? hit_way : victim_way;

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= LOOKUP;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d        = state_q;
    bus.resp_ready = 1'b0;
    bus.resp_rdata = '0;
    mem_valid      = 1'b0;
    mem_cmd        = MEM_READ;
    mem_addr       = '0;
    mem_wdata      = '0;
    wr_en          = 1'b0;
    wr_way         = victim_way;
    wr_data        = mem_rdata;
    wr_tag         = lookup_tag;
    wr_dirty       = 1'b0;
    touch          = 1'b0;
    touch_way      = victim_way;

    case (state_q)
      LOOKUP: begin
        if (bus.req_valid && hit) begin
          bus.resp_ready = 1'b1;
          bus.resp_rdata = rd_data;
          touch          = 1'b1;
          touch_way      = hit_way;
          if (bus.req_wen) begin
            wr_en    = 1'b1;
            wr_way   = hit_way;
            wr_data  = bus.req_wdata;
            wr_dirty = 1'b1;
          end
        end else if (bus.req_valid) begin
          state_d = rd_dirty ? WRITEBACK : ALLOCATE;
        end
      end
      WRITEBACK: begin
        // Victim goes back to its own block address
        mem_valid = 1'b1;
        mem_cmd   = MEM_WRITE;
        mem_addr  = {rd_tag, lookup_set, {OFFSET_BITS{1'b0}}};
        mem_wdata = rd_data;
        if (mem_ready) begin
          state_d = ALLOCATE;
        end
      end
      ALLOCATE: begin
        mem_valid = 1'b1;
        mem_addr  = {lookup_tag, lookup_set, {OFFSET_BITS{1'b0}}};
        if (mem_ready) begin
          // Install clean, the retried lookup then hits
          wr_en   = 1'b1;
          touch   = 1'b1;
          state_d = LOOKUP;
        end
      end
      default: state_d = LOOKUP;
    endcase
  end

endmodule

`default_nettype wire

/* l2_top.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_top
  import cache_pkg::*;
  import bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n,
  input  logic     l1_valid,
  input  logic     l1_wen,
  input  addr_t    l1_addr,
  input  block_t   l1_wdata,
  output logic     l1_ready,
  output block_t   l1_rdata,
  output logic     mem_valid,
  output mem_cmd_e mem_cmd,
  output addr_t    mem_addr,
  output block_t   mem_wdata,
  input  logic     mem_ready,
  input  block_t   mem_rdata
);

  set_idx_t lookup_set;
  tag_t     lookup_tag;
  logic     hit;
  way_idx_t hit_way;
  way_idx_t rd_way;
  block_t   rd_data;
  tag_t     rd_tag;
  logic     rd_dirty;
  logic     wr_en;
  way_idx_t wr_way;
  block_t   wr_data;
  tag_t     wr_tag;
  logic     wr_dirty;
  logic     touch;
  way_idx_t touch_way;
  way_idx_t victim_way;

  l1_l2_if bus_if ();

  l1_l2_bridge u_bridge (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .l1_valid (l1_valid),
    .l1_wen   (l1_wen),
    .l1_addr  (l1_addr),
    .l1_wdata (l1_wdata),
    .l1_ready (l1_ready),
    .l1_rdata (l1_rdata),
    .bus      (bus_if.bridge_mp)
  );

  l2_cache_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .bus        (bus_if.cache_mp),
    .mem_valid  (mem_valid),
    .mem_cmd    (mem_cmd),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata),
    .lookup_set (lookup_set),
    .lookup_tag (lookup_tag),
    .hit        (hit),
    .hit_way    (hit_way),
    .rd_way     (rd_way),
    .rd_data    (rd_data),
    .rd_tag     (rd_tag),
    .rd_dirty   (rd_dirty),
    .wr_en      (wr_en),
    .wr_way     (wr_way),
    .wr_data    (wr_data),
    .wr_tag     (wr_tag),
    .wr_dirty   (wr_dirty),
    .touch      (touch),
    .touch_way  (touch_way),
    .victim_way (victim_way)
  );

  l2_array u_array (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .lookup_set (lookup_set),
    .lookup_tag (lookup_tag),
    .hit        (hit),
    .hit_way    (hit_way),
    .rd_way     (rd_way),
    .rd_data    (rd_data),
    .rd_tag     (rd_tag),
    .rd_dirty   (rd_dirty),
    .wr_en      (wr_en),
    .wr_way     (wr_way),
    .wr_data    (wr_data),
    .wr_tag     (wr_tag),
    .wr_dirty   (wr_dirty)
  );

  l2_lru u_lru (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .set_idx    (lookup_set),
    .touch      (touch),
    .touch_way  (touch_way),
    .victim_way (victim_way)
  );

endmodule

`default_nettype wire

/* l2_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_asserts
  import bus_pkg::*;
(
  input logic        clk_i,
  input logic        rst_n,
  input logic        l1_ready,
  input logic        mem_valid,
  input mem_cmd_e    mem_cmd,
  input addr_t       mem_addr,
  input block_t      mem_wdata,
  input logic        mem_ready,
  input ctrl_state_e ctrl_state
);

  int error_count = 0;

  // Memory request held until the memory answers
  mem_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
    (mem_valid && !mem_ready) |=>
      (mem_valid && $stable(mem_cmd) && $stable(mem_addr) && $stable(mem_wdata)))
    else begin
      error_count++;
      $error("memory request changed before mem_ready");
    end

  ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_n)
    l1_ready |=> !l1_ready)
    else begin
      error_count++;
      $error("l1_ready high for two cycles");
    end

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n |-> (!l1_ready && !mem_valid))
    else begin
      error_count++;
      $error("l1_ready or mem_valid high during reset");
    end

  write_in_wb: assert property (@(posedge clk_i) disable iff (!rst_n)
    (mem_cmd == MEM_WRITE) |-> (ctrl_state == WRITEBACK))
    else begin
      error_count++;
      $error("MEM_WRITE outside the writeback state");
    end

endmodule

bind l2_top l2_asserts u_asserts (
  .clk_i      (clk_i),
  .rst_n      (rst_n),
  .l1_ready   (l1_ready),
  .mem_valid  (mem_valid),
  .mem_cmd    (mem_cmd),
  .mem_addr   (mem_addr),
  .mem_wdata  (mem_wdata),
  .mem_ready  (mem_ready),
  .ctrl_state (u_ctrl.state_q)
);

`default_nettype wire

/* tb_l2_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_l2_top
  import cache_pkg::*;
  import bus_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 10;
  localparam logic [31:0] SEED = 32'd63;
  localparam int MAX_LATENCY = 5;
  localparam int DIRECTED_REQS = 15;
  localparam int RANDOM_REQS = 300;
  localparam int CYCLE_LIMIT = 200 * (DIRECTED_REQS + RANDOM_REQS) + RESET_CYCLES + 20;

  logic     clk_i;
  logic     rst_n;
  logic     l1_valid;
  logic     l1_wen;
  addr_t    l1_addr;
  block_t   l1_wdata;
  logic     l1_ready;
  block_t   l1_rdata;
  logic     mem_valid;
  mem_cmd_e mem_cmd;
  addr_t    mem_addr;
  block_t   mem_wdata;
  logic     mem_ready;
  block_t   mem_rdata;

  block_t   mem_store [addr_t];
  block_t   image [addr_t];
  // Reference copy of tags, state bits and recency lists
  tag_t     ref_tag [SET_NUM][WAY_NUM];
  logic     ref_valid [SET_NUM][WAY_NUM];
  logic     ref_dirty [SET_NUM][WAY_NUM];
  int       ref_order [SET_NUM][WAY_NUM];
  mem_cmd_e xfer_cmd [$];
  addr_t    xfer_addr [$];
  logic     cur_wen;
  addr_t    cur_addr;
  logic [31:0] rng_state = SEED;
  int checks = 0;
  int mismatches = 0;
  int timeouts = 0;
  int cycle_cnt = 0;

  l2_top UUT (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .l1_valid  (l1_valid),
    .l1_wen    (l1_wen),
    .l1_addr   (l1_addr),
    .l1_wdata  (l1_wdata),
    .l1_ready  (l1_ready),
    .l1_rdata  (l1_rdata),
    .mem_valid (mem_valid),
    .mem_cmd   (mem_cmd),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic addr_t block_addr(input addr_t a);
    return {a[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  endfunction

  function automatic addr_t make_addr(input tag_t t, input set_idx_t s);
    return {t, s, {OFFSET_BITS{1'b0}}};
  endfunction

  // Contents of a block never written
  function automatic block_t fill_pattern(input addr_t a);
    return {a ^ 32'h5A5A_A5A5, ~a, a * 32'h9E37_79B9, {a[15:0], a[31:16]}};
  endfunction

  function automatic block_t mem_fetch(input addr_t a);
    return mem_store.exists(a) ? mem_store[a] : fill_pattern(a);
  endfunction

  // Latest value of a block as seen from the L1 side
  function automatic block_t expected_block(input addr_t a);
    return image.exists(a) ? image[a] : fill_pattern(a);
  endfunction

  function automatic void move_to_front(input int s, input int way);
    int pos;
    pos = 0;
    for (int i = 0; i < WAY_NUM; i++) begin
      if (ref_order[s][i] == way) begin
        pos = i;
      end
    end
    for (int i = pos; i > 0; i--) begin
      ref_order[s][i] = ref_order[s][i-1];
    end
    ref_order[s][0] = way;
  endfunction

  // Predicts hit, writeback and victim address, then updates the reference state
  function automatic void predict_access(input logic wen, input addr_t a, output logic hit,
                                         output logic wb, output addr_t wb_addr);
    int   s;
    int   way;
    tag_t t;
    s = int'(a[OFFSET_BITS +: SET_BITS]);
    t = a[ADDR_BITS-1 -: TAG_BITS];
    hit = 1'b0;
    wb = 1'b0;
    wb_addr = '0;
    way = 0;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (!hit && ref_valid[s][w] && ref_tag[s][w] == t) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      way = ref_order[s][WAY_NUM-1];
      if (ref_valid[s][way] && ref_dirty[s][way]) begin
        wb = 1'b1;
        wb_addr = make_addr(ref_tag[s][way], set_idx_t'(s));
      end
      ref_valid[s][way] = 1'b1;
      ref_tag[s][way] = t;
      ref_dirty[s][way] = 1'b0;
    end
    if (wen) begin
      ref_dirty[s][way] = 1'b1;
    end
    move_to_front(s, way);
  endfunction

  task automatic clear_reference();
    for (int s = 0; s < SET_NUM; s++) begin
      for (int w = 0; w < WAY_NUM; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_dirty[s][w] = 1'b0;
        ref_tag[s][w] = '0;
        ref_order[s][w] = w;
      end
    end
  endtask

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic random_block(output block_t b);
    for (int i = 0; i < 4; i++) begin
      b[32*i +: 32] = next_random();
    end
  endtask

  task automatic print_counts();
    $display("Checks: %0d, mismatches: %0d, assertion failures: %0d, timeouts: %0d",
             checks, mismatches, UUT.u_asserts.error_count, timeouts);
  endtask

  task automatic run_access(input logic wen, input addr_t a, input block_t wdata);
    logic  exp_hit;
    logic  exp_wb;
    addr_t wb_addr;
    int    waited;
    int    exp_xfers;
    int    last;
    @(posedge clk_i);
    #1;
    predict_access(wen, a, exp_hit, exp_wb, wb_addr);
    xfer_cmd.delete();
    xfer_addr.delete();
    cur_wen = wen;
    cur_addr = a;
    l1_valid = 1'b1;
    l1_wen = wen;
    l1_addr = a;
    l1_wdata = wdata;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!l1_ready);
    #1;
    l1_valid = 1'b0;
    if (wen) begin
      image[block_addr(a)] = wdata;
    end
    exp_xfers = (exp_hit ? 0 : 1) + (exp_wb ? 1 : 0);
    check_value("memory transfer count", xfer_cmd.size(), exp_xfers);
    if (exp_hit) begin
      check_value("hit latency", waited, 2);
    end
    if (xfer_cmd.size() == exp_xfers && exp_xfers > 0) begin
      last = exp_xfers - 1;
      if (exp_wb) begin
        check_value("writeback command", xfer_cmd[0], MEM_WRITE);
        check_value("writeback address", xfer_addr[0], wb_addr);
      end
      check_value("refill command", xfer_cmd[last], MEM_READ);
      check_value("refill address", xfer_addr[last], block_addr(a));
    end
  endtask

  // Memory answers each command after a random latency
  initial begin : memory_model
    int lat;
    mem_ready = 1'b0;
    mem_rdata = '0;
    forever begin
      @(posedge clk_i);
      if (rst_n && mem_valid) begin
        lat = int'(next_random() % (MAX_LATENCY + 1));
        repeat (lat) @(posedge clk_i);
        #1;
        if (mem_cmd == MEM_WRITE) begin
          mem_store[mem_addr] = mem_wdata;
        end else begin
          mem_rdata = mem_fetch(mem_addr);
        end
        mem_ready = 1'b1;
        @(posedge clk_i);
        #1;
        mem_ready = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_n && l1_ready && !cur_wen) begin
      check_value("read data", l1_rdata, expected_block(block_addr(cur_addr)));
    end
    if (rst_n && mem_valid && mem_ready) begin
      xfer_cmd.push_back(mem_cmd);
      xfer_addr.push_back(mem_addr);
      if (mem_cmd == MEM_WRITE) begin
        check_value("writeback data", mem_wdata, expected_block(mem_addr));
      end
    end
  end

  initial begin : watchdog
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    timeouts++;
    $display("ERROR: timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
    print_counts();
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    block_t      data;
    addr_t       a;
    logic [31:0] r;
    tag_t        t;
    set_idx_t    s;
    rst_n = 1'b1;
    l1_valid = 1'b0;
    l1_wen = 1'b0;
    l1_addr = '0;
    l1_wdata = '0;
    cur_wen = 1'b1;
    cur_addr = '0;
    clear_reference();
    #1;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n = 1'b1;

    repeat (3) begin
      @(posedge clk_i);
      check_value("l1_ready after reset", l1_ready, 1'b0);
      check_value("mem_valid after reset", mem_valid, 1'b0);
    end

    // Read miss, then the same block again as a hit
    a = make_addr(22'h0001A, 6'd3);
    run_access(1'b0, a, '0);
    run_access(1'b0, a, '0);

    // Write miss with a clean victim, then write hit
    a = make_addr(22'h0002B, 6'd9);
    random_block(data);
    run_access(1'b1, a, data);
    run_access(1'b0, a, '0);
    random_block(data);
    run_access(1'b1, a, data);
    run_access(1'b0, a, '0);

    // Six tags in set 17, order B A D C before the fifth tag arrives
    s = 6'd17;
    random_block(data);
    run_access(1'b0, make_addr(22'h100, s), '0);
    run_access(1'b1, make_addr(22'h101, s), data);
    run_access(1'b0, make_addr(22'h102, s), '0);
    random_block(data);
    run_access(1'b1, make_addr(22'h103, s), data);
    run_access(1'b0, make_addr(22'h100, s), '0);
    run_access(1'b0, make_addr(22'h101, s), '0);
    run_access(1'b0, make_addr(22'h104, s), '0);
    random_block(data);
    run_access(1'b1, make_addr(22'h105, s), data);
    run_access(1'b0, make_addr(22'h103, s), '0);

    for (int i = 0; i < RANDOM_REQS; i++) begin
      r = next_random();
      s = {4'b1010, r[1:0]};
      t = tag_t'(32'h200 + r[4:2]);
      a = {t, s, r[8:5]};
      random_block(data);
      run_access(r[9], a, r[9] ? data : '0);
    end

    @(posedge clk_i);
    print_counts();
    if (mismatches == 0 && UUT.u_asserts.error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
cache_pkg.sv
bus_pkg.sv
l1_l2_if.sv
l1_l2_bridge.sv
l2_array.sv
l2_lru.sv
l2_cache_ctrl.sv
l2_top.sv
l2_asserts.sv
tb_l2_top.sv
